//--- include/rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data and address width
`define CORE_XLEN 32

// register index width and count
`define CORE_REG_AW 5
`define CORE_NREGS 32

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- rtl/rv_alu.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_alu (
	input  logic                  clk,
	input  logic                  rstn,
	input  rv_core_pkg::alu_op_e  alu_op,
	input  logic [`CORE_XLEN-1:0] src_a,
	input  logic [`CORE_XLEN-1:0] src_b,
	output logic [`CORE_XLEN-1:0] result
);
	import rv_core_pkg::*;

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;
	logic eq;

	assign shamt = src_b[4:0];
	assign lt_s = $signed(src_a) < $signed(src_b);
	assign lt_u = src_a < src_b;
	assign eq = src_a == src_b;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			case (alu_op)
				alu_add: result <= src_a + src_b;
				alu_sub: result <= src_a - src_b;
				alu_slt: result <= {{(`CORE_XLEN-1){1'b0}}, lt_s};
				alu_sltu: result <= {{(`CORE_XLEN-1){1'b0}}, lt_u};
				alu_xor: result <= src_a ^ src_b;
				alu_or: result <= src_a | src_b;
				alu_and: result <= src_a & src_b;
				alu_sll: result <= src_a << shamt;
				alu_srl: result <= src_a >> shamt;
				alu_sra: result <= $signed(src_a) >>> shamt;
				// branch compares, nonzero means taken
				alu_eq: result <= {{(`CORE_XLEN-1){1'b0}}, eq};
				alu_ne: result <= {{(`CORE_XLEN-1){1'b0}}, !eq};
				alu_lt: result <= {{(`CORE_XLEN-1){1'b0}}, lt_s};
				alu_ge: result <= {{(`CORE_XLEN-1){1'b0}}, !lt_s};
				alu_ltu: result <= {{(`CORE_XLEN-1){1'b0}}, lt_u};
				default: result <= {{(`CORE_XLEN-1){1'b0}}, !lt_u};
			endcase
		end
	end

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_core (
	input  logic                    clk,
	input  logic                    rstn,
	output logic                    mem_valid,
	output logic [`CORE_XLEN-1:0]   mem_addr,
	output logic                    mem_write,
	output logic [`CORE_XLEN/8-1:0] mem_wstrb,
	output logic [`CORE_XLEN-1:0]   mem_wdata,
	input  logic                    mem_ready,
	input  logic [`CORE_XLEN-1:0]   mem_rdata,
	output logic                    halted,
	output logic                    illegal
);
	import rv_core_pkg::*;

	core_state_e state;
	logic [`CORE_XLEN-1:0] pc;
	logic [`CORE_XLEN-1:0] instr_q;
	logic [`CORE_XLEN-1:0] load_q;
	logic [`CORE_REG_AW-1:0] rs1;
	logic [`CORE_REG_AW-1:0] rs2;
	logic [`CORE_REG_AW-1:0] rd;
	logic [`CORE_XLEN-1:0] imm;
	op_class_e op_class;
	alu_op_e alu_op;
	mem_size_e mem_size;
	logic mem_unsigned;
	logic [`CORE_XLEN-1:0] rdata1;
	logic [`CORE_XLEN-1:0] rdata2;
	logic [`CORE_XLEN-1:0] alu_src_b;
	logic [`CORE_XLEN-1:0] alu_result;
	logic [`CORE_XLEN-1:0] lsu_addr;
	logic [`CORE_XLEN/8-1:0] lsu_wstrb;
	logic [`CORE_XLEN-1:0] lsu_wdata;
	logic [`CORE_XLEN-1:0] load_data;
	logic misaligned;
	logic is_mem;
	logic is_store;
	logic reg_wen;
	logic [`CORE_XLEN-1:0] wb_data;
	logic [`CORE_XLEN-1:0] pc_plus4;
	logic [`CORE_XLEN-1:0] pc_next;

	rv_decoder i_decoder (.clk(clk), .instr(instr_q), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.op_class(op_class), .alu_op(alu_op), .mem_size(mem_size), .mem_unsigned(mem_unsigned));

	rv_regfile i_regfile (.clk(clk), .rstn(rstn), .rs1(rs1), .rs2(rs2), .rd(rd), .wen(reg_wen),
		.wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2));

	// op and branch compare registers, the rest take the immediate
	assign alu_src_b = (op_class == cls_branch || (op_class == cls_alu && instr_q[5])) ?
		rdata2 : imm;

	rv_alu i_alu (.clk(clk), .rstn(rstn), .alu_op(alu_op), .src_a(rdata1), .src_b(alu_src_b),
		.result(alu_result));

	rv_lsu i_lsu (.base(rdata1), .offset(imm), .store_data(rdata2), .mem_size(mem_size),
		.mem_unsigned(mem_unsigned), .rdata(mem_rdata), .addr(lsu_addr), .wstrb(lsu_wstrb),
		.wdata(lsu_wdata), .load_data(load_data), .misaligned(misaligned));

	assign is_store = op_class == cls_store;
	assign is_mem = is_store || op_class == cls_load;
	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		case (op_class)
			cls_lui: wb_data = imm;
			cls_auipc: wb_data = pc + imm;
			cls_jal, cls_jalr: wb_data = pc_plus4;
			cls_load: wb_data = load_q;
			default: wb_data = alu_result;
		endcase
	end

	assign reg_wen = state == st_write && (op_class == cls_alu || op_class == cls_lui ||
		op_class == cls_auipc || op_class == cls_jal || op_class == cls_jalr ||
		op_class == cls_load);

	always_comb begin
		case (op_class)
			cls_jal: pc_next = pc + imm;
			cls_jalr: pc_next = {alu_result[`CORE_XLEN-1:1], 1'b0}; // rs1 + imm from alu
			cls_branch: pc_next = (alu_result != '0) ? pc + imm : pc_plus4;
			default: pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_fetch;
			pc <= `CORE_RESET_PC;
			mem_valid <= 1'b0;
			mem_write <= 1'b0;
			halted <= 1'b0;
			illegal <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!mem_valid) begin
						mem_valid <= 1'b1;
						mem_addr <= pc;
						mem_write <= 1'b0;
						mem_wstrb <= '0;
					end else if (mem_ready) begin
						mem_valid <= 1'b0;
						instr_q <= mem_rdata;
						state <= st_decode;
					end
				end
				st_decode: state <= st_exec;
				st_exec: begin
					if (op_class == cls_ecall || op_class == cls_illegal) begin
						halted <= 1'b1;
						illegal <= op_class == cls_illegal;
						state <= st_halt;
					end else begin
						state <= st_mem;
					end
				end
				st_mem: begin
					if (!is_mem) begin
						state <= st_write;
					end else if (misaligned) begin
						halted <= 1'b1; // no bus request goes out
						illegal <= 1'b1;
						state <= st_halt;
					end else if (!mem_valid) begin
						mem_valid <= 1'b1;
						mem_addr <= {lsu_addr[`CORE_XLEN-1:2], 2'b00};
						mem_write <= is_store;
						mem_wstrb <= is_store ? lsu_wstrb : '0;
						mem_wdata <= lsu_wdata;
					end else if (mem_ready) begin
						mem_valid <= 1'b0;
						load_q <= load_data; // rdata only valid in this cycle
						state <= st_write;
					end
				end
				st_write: begin
					pc <= pc_next;
					state <= st_fetch;
				end
				default: state <= st_halt;
			endcase
		end
	end

endmodule

//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_exec,
		st_mem,
		st_write,
		st_halt
	} core_state_e;

	// rv32i major opcodes
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_imm    = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_xor, alu_or, alu_and, alu_sll,
		alu_srl, alu_sra, alu_eq, alu_ne,
		alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	typedef enum logic [1:0] {
		size_byte,
		size_half,
		size_word
	} mem_size_e;

	typedef enum logic [3:0] {
		cls_alu, cls_lui, cls_auipc, cls_jal, cls_jalr,
		cls_branch, cls_load, cls_store, cls_ecall, cls_illegal
	} op_class_e;

endpackage

//--- rtl/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_decoder (
	input  logic                    clk,
	input  logic [`CORE_XLEN-1:0]   instr,
	output logic [`CORE_REG_AW-1:0] rs1,
	output logic [`CORE_REG_AW-1:0] rs2,
	output logic [`CORE_REG_AW-1:0] rd,
	output logic [`CORE_XLEN-1:0]   imm,
	output rv_core_pkg::op_class_e  op_class,
	output rv_core_pkg::alu_op_e    alu_op,
	output rv_core_pkg::mem_size_e  mem_size,
	output logic                    mem_unsigned
);
	import rv_core_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic f7_zero;
	logic f7_alt;
	logic is_op;
	logic alu_ok;
	logic uses_rs1;
	logic uses_rs2;
	logic [`CORE_XLEN-1:0] imm_i;
	logic [`CORE_XLEN-1:0] imm_s;
	logic [`CORE_XLEN-1:0] imm_b;
	logic [`CORE_XLEN-1:0] imm_u;
	logic [`CORE_XLEN-1:0] imm_j;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign f7_zero = instr[31:25] == 7'b0000000;
	assign f7_alt = instr[31:25] == 7'b0100000;
	assign is_op = instr[5]; // register-register form

	// only sub and sra take the alternate funct7, shifts-immediate are strict
	assign alu_ok = is_op ? (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) :
		(funct3 == 3'b001) ? f7_zero :
		(funct3 == 3'b101) ? (f7_zero || f7_alt) : 1'b1;

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			opc_jalr, opc_load, opc_imm: uses_rs1 = 1'b1;
			opc_branch, opc_store, opc_op: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			default: uses_rs1 = 1'b0;
		endcase
	end

	assign rs1 = uses_rs1 ? instr[19:15] : '0; // read ports see these before the edge
	assign rs2 = uses_rs2 ? instr[24:20] : '0;

	always_ff @(posedge clk) begin
		rd <= instr[11:7];
		imm <= '0;
		op_class <= cls_illegal;
		alu_op <= alu_add;
		mem_size <= size_word;
		mem_unsigned <= 1'b0;
		case (opcode)
			opc_lui: begin
				op_class <= cls_lui;
				imm <= imm_u;
			end
			opc_auipc: begin
				op_class <= cls_auipc;
				imm <= imm_u;
			end
			opc_jal: begin
				op_class <= cls_jal;
				imm <= imm_j;
			end
			opc_jalr: begin
				if (funct3 == 3'b000)
					op_class <= cls_jalr; // target comes from alu add
				imm <= imm_i;
			end
			opc_branch: begin
				op_class <= cls_branch;
				imm <= imm_b;
				case (funct3)
					3'b000: alu_op <= alu_eq;
					3'b001: alu_op <= alu_ne;
					3'b100: alu_op <= alu_lt;
					3'b101: alu_op <= alu_ge;
					3'b110: alu_op <= alu_ltu;
					3'b111: alu_op <= alu_geu;
					default: op_class <= cls_illegal;
				endcase
			end
			opc_load: begin
				op_class <= cls_load;
				imm <= imm_i;
				mem_unsigned <= funct3[2];
				case (funct3)
					3'b000, 3'b100: mem_size <= size_byte;
					3'b001, 3'b101: mem_size <= size_half;
					3'b010: mem_size <= size_word;
					default: op_class <= cls_illegal;
				endcase
			end
			opc_store: begin
				op_class <= cls_store;
				imm <= imm_s;
				case (funct3)
					3'b000: mem_size <= size_byte;
					3'b001: mem_size <= size_half;
					3'b010: mem_size <= size_word;
					default: op_class <= cls_illegal;
				endcase
			end
			opc_imm, opc_op: begin
				op_class <= alu_ok ? cls_alu : cls_illegal;
				imm <= imm_i;
				case (funct3)
					3'b000: alu_op <= (is_op && f7_alt) ? alu_sub : alu_add;
					3'b001: alu_op <= alu_sll;
					3'b010: alu_op <= alu_slt;
					3'b011: alu_op <= alu_sltu;
					3'b100: alu_op <= alu_xor;
					3'b101: alu_op <= f7_alt ? alu_sra : alu_srl;
					3'b110: alu_op <= alu_or;
					default: alu_op <= alu_and;
				endcase
			end
			opc_system: begin
				if (instr == 32'h0000_0073)
					op_class <= cls_ecall; // anything else in system space is illegal
			end
			default: op_class <= cls_illegal;
		endcase
	end

endmodule

//--- rtl/rv_lsu.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_lsu (
	input  logic [`CORE_XLEN-1:0]   base,
	input  logic [`CORE_XLEN-1:0]   offset,
	input  logic [`CORE_XLEN-1:0]   store_data,
	input  rv_core_pkg::mem_size_e  mem_size,
	input  logic                    mem_unsigned,
	input  logic [`CORE_XLEN-1:0]   rdata,
	output logic [`CORE_XLEN-1:0]   addr,
	output logic [`CORE_XLEN/8-1:0] wstrb,
	output logic [`CORE_XLEN-1:0]   wdata,
	output logic [`CORE_XLEN-1:0]   load_data,
	output logic                    misaligned
);
	import rv_core_pkg::*;

	logic [4:0] byte_sh;
	logic [4:0] half_sh;
	logic [`CORE_XLEN-1:0] byte_lane;
	logic [`CORE_XLEN-1:0] half_lane;

	assign addr = base + offset;

	// big endian, byte 0 sits in bits 31:24
	assign byte_sh = {addr[1:0], 3'b000};
	assign half_sh = {addr[1], 4'b0000};
	assign byte_lane = rdata << byte_sh; // addressed byte moved to the top
	assign half_lane = rdata << half_sh;

	always_comb begin
		case (mem_size)
			size_byte: begin
				wstrb = 4'b1000 >> addr[1:0];
				wdata = {store_data[7:0], 24'b0} >> byte_sh;
				misaligned = 1'b0;
			end
			size_half: begin
				wstrb = 4'b1100 >> {addr[1], 1'b0};
				wdata = {store_data[15:0], 16'b0} >> half_sh;
				misaligned = addr[0];
			end
			default: begin
				wstrb = 4'b1111;
				wdata = store_data;
				misaligned = addr[1:0] != 2'b00;
			end
		endcase
	end

	always_comb begin
		case (mem_size)
			size_byte: begin
				if (mem_unsigned)
					load_data = {24'b0, byte_lane[31:24]};
				else
					load_data = {{24{byte_lane[31]}}, byte_lane[31:24]};
			end
			size_half: begin
				if (mem_unsigned)
					load_data = {16'b0, half_lane[31:16]};
				else
					load_data = {{16{half_lane[31]}}, half_lane[31:16]};
			end
			default: load_data = rdata;
		endcase
	end

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_regfile (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic [`CORE_REG_AW-1:0] rs1,
	input  logic [`CORE_REG_AW-1:0] rs2,
	input  logic [`CORE_REG_AW-1:0] rd,
	input  logic                    wen,
	input  logic [`CORE_XLEN-1:0]   wdata,
	output logic [`CORE_XLEN-1:0]   rdata1,
	output logic [`CORE_XLEN-1:0]   rdata2
);

	logic [`CORE_XLEN-1:0] regs [1:`CORE_NREGS-1]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// synchronous read, never in the same cycle as a write
	always_ff @(posedge clk) begin
		rdata1 <= (rs1 == '0) ? '0 : regs[rs1];
		rdata2 <= (rs2 == '0) ? '0 : regs[rs2];
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_core.f --top-module tb_rv_core \
	-o sim_rv_core --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
echo "Simulation passed"
exit 0

//--- rv_core.f
+incdir+include
rtl/rv_core_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
test/tb_mem_model.sv
test/tb_rv_core.sv

//--- test/tb_mem_model.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module tb_mem_model #(
	parameter int MEM_WORDS = 2048
) (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    mem_valid,
	input  logic [`CORE_XLEN-1:0]   mem_addr,
	input  logic                    mem_write,
	input  logic [`CORE_XLEN/8-1:0] mem_wstrb,
	input  logic [`CORE_XLEN-1:0]   mem_wdata,
	output logic                    mem_ready = 1'b0,
	output logic [`CORE_XLEN-1:0]   mem_rdata = '0,
	output logic                    st_valid = 1'b0,
	output logic [`CORE_XLEN-1:0]   st_addr,
	output logic [`CORE_XLEN/8-1:0] st_strb,
	output logic [`CORE_XLEN-1:0]   st_data
);
	localparam int AW = $clog2(MEM_WORDS);

	logic [`CORE_XLEN-1:0] mem [MEM_WORDS]; // loaded by the testbench
	logic [AW-1:0] widx;
	logic [`CORE_XLEN-1:0] lane_mask;
	logic [2:0] wait_cnt;

	assign widx = mem_addr[AW+1:2];

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			lane_mask[k*8 +: 8] = {8{mem_wstrb[k]}};
		end
	end

	always @(posedge clk) begin
		st_valid <= 1'b0;
		if (!rstn) begin
			mem_ready <= 1'b0;
			wait_cnt <= '0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0; // handshake completes in this cycle
			if (mem_write) begin
				mem[widx] = (mem[widx] & ~lane_mask) | (mem_wdata & lane_mask);
				st_valid <= 1'b1;
				st_addr <= mem_addr;
				st_strb <= mem_wstrb;
				st_data <= mem_wdata & lane_mask;
			end
		end else if (mem_valid) begin
			if (wait_cnt == '0) begin
				mem_ready <= 1'b1;
				mem_rdata <= mem[widx];
				wait_cnt <= 3'($urandom % 5); // delay for the next request
			end else begin
				wait_cnt <= wait_cnt - 3'd1;
			end
		end
	end

endmodule

//--- test/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module tb_rv_core;
	import rv_core_pkg::*;

	localparam int MEM_WORDS = 2048;
	localparam int NPROG = 8;
	localparam int NSEG = 24;
	localparam int STEP_LIMIT = 20000;
	localparam int HALT_TIMEOUT = 100000;

	logic clk;
	logic rstn;
	logic mem_valid;
	logic [31:0] mem_addr;
	logic mem_write;
	logic [3:0] mem_wstrb;
	logic [31:0] mem_wdata;
	logic mem_ready;
	logic [31:0] mem_rdata;
	logic halted;
	logic illegal;
	logic st_valid;
	logic [31:0] st_addr;
	logic [3:0] st_strb;
	logic [31:0] st_data;

	logic [31:0] prog [$];
	logic [31:0] ref_mem [MEM_WORDS];
	logic [31:0] exp_addr [$];
	logic [3:0] exp_strb [$];
	logic [31:0] exp_data [$];
	logic exp_illegal;
	logic [11:0] slot_off;
	logic [2:0] branch_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

	rv_core i_dut (.clk(clk), .rstn(rstn), .mem_valid(mem_valid), .mem_addr(mem_addr),
		.mem_write(mem_write), .mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata), .halted(halted), .illegal(illegal));

	tb_mem_model #(.MEM_WORDS(MEM_WORDS)) i_mem (.clk(clk), .rstn(rstn),
		.mem_valid(mem_valid), .mem_addr(mem_addr), .mem_write(mem_write),
		.mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
		.mem_rdata(mem_rdata), .st_valid(st_valid), .st_addr(st_addr), .st_strb(st_strb),
		.st_data(st_data));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic void stop_with_error(string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endfunction

	function automatic logic [31:0] rnd(logic [31:0] n);
		return $urandom % n;
	endfunction

	function automatic logic [31:0] strb_mask(logic [3:0] s);
		logic [31:0] m;
		for (int k = 0; k < 4; k++) begin
			m[k*8 +: 8] = {8{s[k]}};
		end
		return m;
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'(opc_op)};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// stores always use x1 as base
	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
		return {imm[11:5], rs2, 5'd1, f3, imm[4:0], 7'(opc_store)};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'(opc_branch)};
	endfunction

	function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'(opc_jal)};
	endfunction

	function automatic void emit(logic [31:0] w);
		prog.push_back(w);
	endfunction

	function automatic logic [11:0] next_slot();
		slot_off = slot_off + 12'd4;
		return slot_off - 12'd4;
	endfunction

	function automatic void store_reg(logic [4:0] r);
		emit(enc_s(next_slot(), r, 3'b010));
	endfunction

	function automatic void set_reg(logic [4:0] r);
		emit(enc_u(20'(rnd(32'h0010_0000)), r, opc_lui));
		emit(enc_i(12'(rnd(4096)), r, 3'b000, r, opc_imm));
	endfunction

	function automatic void gen_segment(int kind);
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] off;
		logic [11:0] imm;
		rd = 5'(2 + rnd(6));
		rs1 = 5'(rnd(8));
		rs2 = 5'(rnd(8));
		f3 = 3'(rnd(8));
		case (kind)
			0: begin
				if (rnd(2) == 0) begin
					f7 = ((f3 == 3'b000 || f3 == 3'b101) && rnd(2) == 1) ? 7'h20 : 7'h00;
					emit(enc_r(f7, rs2, rs1, f3, rd));
				end else begin
					imm = 12'(rnd(4096));
					if (f3 == 3'b001)
						imm = {7'h00, imm[4:0]};
					else if (f3 == 3'b101)
						imm = {(rnd(2) == 1) ? 7'h20 : 7'h00, imm[4:0]};
					emit(enc_i(imm, rs1, f3, rd, opc_imm));
				end
				store_reg(rd);
			end
			1: begin
				emit(enc_u(20'(rnd(32'h0010_0000)), rd, (rnd(2) == 1) ? opc_lui : opc_auipc));
				store_reg(rd);
			end
			2: begin
				emit(enc_i(12'd5, 5'd0, 3'b000, 5'd10, opc_imm));
				emit(enc_j(21'd8, 5'd9)); // skips the next one
				emit(enc_i(12'd7, 5'd0, 3'b000, 5'd10, opc_imm));
				store_reg(5'd9);
				store_reg(5'd10);
			end
			3: begin
				emit(enc_i(12'd6, 5'd0, 3'b000, 5'd10, opc_imm));
				emit(enc_u(20'd0, 5'd8, opc_auipc));
				emit(enc_i(12'(16 + rnd(2)), 5'd8, 3'b000, 5'd9, opc_jalr)); // odd target too
				emit(enc_i(12'd3, 5'd0, 3'b000, 5'd10, opc_imm));
				emit(enc_i(12'd4, 5'd0, 3'b000, 5'd10, opc_imm));
				store_reg(5'd9);
				store_reg(5'd10);
			end
			4: begin
				set_reg(5'd2);
				if (rnd(4) == 0)
					emit(enc_r(7'h00, 5'd0, 5'd2, 3'b000, 5'd3));
				else if (rnd(2) == 0)
					emit(enc_i(12'(rnd(4096)), 5'd2, 3'b000, 5'd3, opc_imm));
				else
					set_reg(5'd3);
				emit(enc_i(12'd1, 5'd0, 3'b000, 5'd10, opc_imm));
				emit(enc_b(13'd8, 5'd3, 5'd2, branch_f3[rnd(6)]));
				emit(enc_i(12'd2, 5'd0, 3'b000, 5'd10, opc_imm));
				store_reg(5'd10);
			end
			default: begin
				off = next_slot();
				if (rnd(2) == 0) begin
					off = off + 12'(rnd(4));
					emit(enc_s(off, rd, 3'b000));
					emit(enc_i(off, 5'd1, 3'b000, 5'd11, opc_load));
					emit(enc_i(off, 5'd1, 3'b100, 5'd12, opc_load));
				end else begin
					off = off + 12'(2 * rnd(2));
					emit(enc_s(off, rd, 3'b001));
					emit(enc_i(off, 5'd1, 3'b001, 5'd11, opc_load));
					emit(enc_i(off, 5'd1, 3'b101, 5'd12, opc_load));
				end
				store_reg(5'd11);
				store_reg(5'd12);
			end
		endcase
	endfunction

	// end kind 0 is ecall, 1 a misaligned lw, 2 an undefined opcode
	function automatic void gen_program(int end_kind);
		logic [31:0] w;
		prog.delete();
		slot_off = '0;
		emit(enc_u(20'h00001, 5'd1, opc_lui)); // data area at 0x1000
		for (int r = 2; r < 8; r++) begin
			set_reg(5'(r));
		end
		for (int s = 0; s < NSEG; s++) begin
			gen_segment(int'(rnd(6)));
		end
		if (end_kind == 0) begin
			emit(32'h0000_0073);
		end else if (end_kind == 1) begin
			emit(enc_i(next_slot() + 12'(1 + rnd(3)), 5'd1, 3'b010, 5'd4, opc_load));
			store_reg(5'd4);
		end else begin
			w = $urandom;
			emit({w[31:7], 7'b0000000});
			store_reg(5'd4);
		end
	endfunction

	function automatic void load_memories();
		logic [31:0] w;
		for (int i = 0; i < MEM_WORDS; i++) begin
			w = (32'(i) * 32'h9E37_79B1) ^ 32'hA5C3_5A3C;
			if (i < prog.size())
				w = prog[i];
			i_mem.mem[i] = w;
			ref_mem[i] = w;
		end
	endfunction

	function automatic int widx(logic [31:0] a);
		return int'(a[12:2]);
	endfunction

	// instruction-set model over big-endian data that collects the expected stores
	function automatic void iss_run();
		logic [31:0] x [32];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] opb;
		logic [31:0] res;
		logic [31:0] nxt;
		logic [31:0] ad;
		logic [31:0] wd;
		logic [31:0] m;
		logic [31:0] immi;
		logic [31:0] imms;
		logic [31:0] immb;
		logic [4:0] sh;
		logic [2:0] f3;
		logic [7:0] bt;
		logic [15:0] hv;
		logic [3:0] st;
		logic wr;
		logic take;
		for (int i = 0; i < 32; i++) begin
			x[i] = '0;
		end
		exp_addr.delete();
		exp_strb.delete();
		exp_data.delete();
		exp_illegal = 1'b1;
		pc = `CORE_RESET_PC;
		for (int step = 0; step < STEP_LIMIT; step++) begin
			w = ref_mem[widx(pc)];
			f3 = w[14:12];
			a = x[w[19:15]];
			b = x[w[24:20]];
			immi = {{20{w[31]}}, w[31:20]};
			imms = {{20{w[31]}}, w[31:25], w[11:7]};
			immb = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			nxt = pc + 32'd4;
			res = '0;
			wr = 1'b1;
			case (w[6:0])
				7'b0110111: res = {w[31:12], 12'b0};
				7'b0010111: res = pc + {w[31:12], 12'b0};
				7'b1101111: begin
					res = pc + 32'd4;
					nxt = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				7'b1100111: begin
					res = pc + 32'd4;
					nxt = (a + immi) & ~32'd1;
				end
				7'b1100011: begin
					wr = 1'b0;
					case (f3)
						3'b000: take = a == b;
						3'b001: take = a != b;
						3'b100: take = $signed(a) < $signed(b);
						3'b101: take = $signed(a) >= $signed(b);
						3'b110: take = a < b;
						3'b111: take = a >= b;
						default: return;
					endcase
					if (take)
						nxt = pc + immb;
				end
				7'b0000011: begin
					ad = a + immi;
					if ((f3[1:0] == 2'b01 && ad[0]) || (f3 == 3'b010 && ad[1:0] != 2'b00))
						return; // misaligned halts as illegal
					wd = ref_mem[widx(ad)];
					bt = wd[(3 - int'(ad[1:0])) * 8 +: 8];
					hv = wd[(1 - int'(ad[1])) * 16 +: 16];
					case (f3)
						3'b000: res = {{24{bt[7]}}, bt};
						3'b100: res = {24'b0, bt};
						3'b001: res = {{16{hv[15]}}, hv};
						3'b101: res = {16'b0, hv};
						3'b010: res = wd;
						default: return;
					endcase
				end
				7'b0100011: begin
					wr = 1'b0;
					ad = a + imms;
					wd = '0;
					st = '0;
					if (f3 == 3'b000) begin
						wd[(3 - int'(ad[1:0])) * 8 +: 8] = b[7:0];
						st[3 - int'(ad[1:0])] = 1'b1;
					end else if (f3 == 3'b001 && !ad[0]) begin
						wd[(1 - int'(ad[1])) * 16 +: 16] = b[15:0];
						st = ad[1] ? 4'b0011 : 4'b1100;
					end else if (f3 == 3'b010 && ad[1:0] == 2'b00) begin
						wd = b;
						st = 4'b1111;
					end else begin
						return;
					end
					m = strb_mask(st);
					exp_addr.push_back({ad[31:2], 2'b00});
					exp_strb.push_back(st);
					exp_data.push_back(wd & m);
					ref_mem[widx(ad)] = (ref_mem[widx(ad)] & ~m) | (wd & m);
				end
				7'b0010011, 7'b0110011: begin
					opb = w[5] ? b : immi;
					sh = w[5] ? b[4:0] : w[24:20];
					case (f3)
						3'b000: res = (w[5] && w[30]) ? a - opb : a + opb;
						3'b001: res = a << sh;
						3'b010: res = {31'b0, $signed(a) < $signed(opb)};
						3'b011: res = {31'b0, a < opb};
						3'b100: res = a ^ opb;
						3'b101: res = w[30] ? 32'($signed(a) >>> sh) : a >> sh;
						3'b110: res = a | opb;
						default: res = a & opb;
					endcase
				end
				7'b1110011: begin
					if (w == 32'h0000_0073)
						exp_illegal = 1'b0;
					return;
				end
				default: return;
			endcase
			if (wr && w[11:7] != 5'd0)
				x[w[11:7]] = res;
			pc = nxt;
		end
		stop_with_error("The reference model ran past its step limit without halting");
	endfunction

	always @(posedge clk) begin
		if (rstn && st_valid) begin
			assert (exp_addr.size() > 0)
			else stop_with_error($sformatf("[FAIL] %0t: unexpected store to %h", $time, st_addr));
			assert (st_addr == exp_addr[0] && st_strb == exp_strb[0] && st_data == exp_data[0])
			else stop_with_error($sformatf(
				"[FAIL] %0t: store %h/%b/%h, expected %h/%b/%h", $time, st_addr, st_strb,
				st_data, exp_addr[0], exp_strb[0], exp_data[0]));
			void'(exp_addr.pop_front());
			void'(exp_strb.pop_front());
			void'(exp_data.pop_front());
		end
	end

	initial begin
		int cycles;
		int end_kind;
		rstn = 1'b0;
		void'($urandom(32'h08915911));
		for (int p = 0; p < NPROG; p++) begin
			end_kind = (p < 5) ? 0 : (p == 6) ? 2 : 1;
			gen_program(end_kind);
			@(posedge clk);
			rstn <= 1'b0;
			load_memories();
			iss_run();
			repeat (5) @(posedge clk);
			rstn <= 1'b1;
			@(negedge clk);
			assert (!mem_valid && !halted && !illegal)
			else stop_with_error($sformatf("[FAIL] %0t: outputs not idle after reset", $time));
			cycles = 0;
			while (!halted) begin
				@(negedge clk);
				cycles++;
				if (cycles > HALT_TIMEOUT)
					stop_with_error($sformatf("Timeout: the core never halted in program %0d", p));
			end
			repeat (20) @(negedge clk); // no store may follow the halt
			assert (exp_addr.size() == 0)
			else stop_with_error($sformatf("[FAIL] %0t: program %0d missed %0d stores", $time, p,
				exp_addr.size()));
			assert (illegal == exp_illegal)
			else stop_with_error($sformatf("[FAIL] %0t: program %0d illegal=%b, expected %b",
				$time, p, illegal, exp_illegal));
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule
